/* hw/gomoku_config.svh */
`ifndef GOMOKU_CONFIG_SVH
`define GOMOKU_CONFIG_SVH

// Board geometry.
`define BOARD_SIZE      15
`define CELL_COUNT      225

`define WIN_FIVE        5
`define WIN_SIX         6

`define SCORE_WIDTH     32

// Class weights.
`define W_FIVE          1000000
`define W_OPEN_FOUR     100000
`define W_BLOCKED_FOUR  10000
`define W_OPEN_THREE    1000
`define W_BLOCKED_THREE 100
`define W_OPEN_TWO      100

`endif

/* hw/gomoku_pkg.sv */
`include "gomoku_config.svh"

package gomoku_pkg;

    // Code 3 is unused and matches no pattern cell.
    typedef enum logic [1:0] {
        CELL_BLACK = 2'd0,
        CELL_WHITE = 2'd1,
        CELL_EMPTY = 2'd2
    } cell_t;

    typedef cell_t column_t [`BOARD_SIZE];                  // Row 0 first, top to bottom.

    typedef logic signed [`SCORE_WIDTH-1:0] score_t;

endpackage

/* hw/column_feeder.sv */
`include "gomoku_config.svh"

module column_feeder (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  logic [2*`CELL_COUNT-1:0]  i_board,
    output logic                      o_col_valid,
    output logic                      o_col_last,
    output gomoku_pkg::column_t       o_col_cells
);

    import gomoku_pkg::*;

    logic [2*`CELL_COUNT-1:0] board_q;
    logic                     busy;
    logic [3:0]               col_cnt;
    logic                     at_last;
    logic                     accept;
    column_t                  next_col;

    assign at_last = busy && (col_cnt == 4'(`BOARD_SIZE - 1));
    assign accept  = i_start && (!busy || at_last);        // Last column frees the feeder.

    // Cells of one column lie BOARD_SIZE apart in the flat board.
    always_comb begin
        for (int r = 0; r < `BOARD_SIZE; r++) begin
            next_col[r] = cell_t'(board_q[2*(r*`BOARD_SIZE + col_cnt) +: 2]);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy        <= 1'b0;
            col_cnt     <= '0;
            o_col_valid <= 1'b0;
            o_col_last  <= 1'b0;
        end else begin
            o_col_valid <= busy;
            o_col_last  <= at_last;
            if (accept) begin
                busy    <= 1'b1;
                col_cnt <= '0;
            end else if (at_last) begin
                busy    <= 1'b0;
                col_cnt <= '0;
            end else if (busy) begin
                col_cnt <= col_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            board_q <= i_board;
        end
        if (busy) begin
            o_col_cells <= next_col;
        end
    end

endmodule

/* hw/line_matcher.sv */
`include "gomoku_config.svh"

module line_matcher #(
    parameter gomoku_pkg::cell_t OWN_COLOR = gomoku_pkg::CELL_BLACK
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_col_valid,
    input  logic                 i_col_last,
    input  gomoku_pkg::column_t  i_col_cells,
    output logic                 o_lane_valid,
    output logic                 o_lane_last,
    output gomoku_pkg::score_t   o_lane_score
);

    import gomoku_pkg::*;

    localparam cell_t OPP_COLOR = (OWN_COLOR == CELL_BLACK) ? CELL_WHITE : CELL_BLACK;
    localparam int    FIVE_POS  = `BOARD_SIZE - `WIN_FIVE + 1;   // On-board 5-cell starts.
    localparam int    SIX_POS   = `BOARD_SIZE - `WIN_SIX + 1;    // On-board 6-cell starts.

    logic [`BOARD_SIZE-1:0] own;
    logic [`BOARD_SIZE-1:0] opp;
    logic [`BOARD_SIZE-1:0] emp;

    logic [FIVE_POS-1:0] five_hit;
    logic [FIVE_POS-1:0] open_three_hit;
    logic [SIX_POS-1:0]  open_four_hit;
    logic [SIX_POS-1:0]  blocked_four_hit;
    logic [SIX_POS-1:0]  blocked_three_hit;
    logic [SIX_POS-1:0]  open_two_hit;

    score_t col_sum;

    always_comb begin
        for (int r = 0; r < `BOARD_SIZE; r++) begin
            own[r] = (i_col_cells[r] == OWN_COLOR);
            opp[r] = (i_col_cells[r] == OPP_COLOR);
            emp[r] = (i_col_cells[r] == CELL_EMPTY);
        end
    end

    // 5-cell windows.
    always_comb begin
        for (int s = 0; s < FIVE_POS; s++) begin
            five_hit[s]       = &own[s +: `WIN_FIVE];
            open_three_hit[s] = emp[s] && (&own[s+1 +: 3]) && emp[s+4];
        end
    end

    // 6-cell windows, blocked shapes in both orientations.
    always_comb begin
        for (int s = 0; s < SIX_POS; s++) begin
            open_four_hit[s] = emp[s] && (&own[s+1 +: 4]) && emp[s+5];

            blocked_four_hit[s] = (&own[s+1 +: 4]) &&
                                  ((emp[s] && opp[s+5]) || (opp[s] && emp[s+5]));

            blocked_three_hit[s] = (emp[s] && emp[s+1] && (&own[s+2 +: 3]) && opp[s+5]) ||
                                   (opp[s] && (&own[s+1 +: 3]) && emp[s+4] && emp[s+5]);

            open_two_hit[s] = emp[s] && emp[s+1] && own[s+2] && own[s+3] &&
                              emp[s+4] && emp[s+5];
        end
    end

    // Overlapping matches all count.
    always_comb begin
        col_sum = '0;
        for (int s = 0; s < FIVE_POS; s++) begin
            if (five_hit[s]) begin
                col_sum = col_sum + `W_FIVE;
            end
            if (open_three_hit[s]) begin
                col_sum = col_sum + `W_OPEN_THREE;
            end
        end
        for (int s = 0; s < SIX_POS; s++) begin
            if (open_four_hit[s]) begin
                col_sum = col_sum + `W_OPEN_FOUR;
            end
            if (blocked_four_hit[s]) begin
                col_sum = col_sum + `W_BLOCKED_FOUR;
            end
            if (blocked_three_hit[s]) begin
                col_sum = col_sum + `W_BLOCKED_THREE;
            end
            if (open_two_hit[s]) begin
                col_sum = col_sum + `W_OPEN_TWO;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_lane_valid <= 1'b0;
            o_lane_last  <= 1'b0;
        end else begin
            o_lane_valid <= i_col_valid;
            o_lane_last  <= i_col_valid && i_col_last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_col_valid) begin
            o_lane_score <= col_sum;
        end
    end

endmodule

/* hw/score_accumulator.sv */
`include "gomoku_config.svh"

module score_accumulator (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_black_valid,
    input  logic                i_black_last,
    input  gomoku_pkg::score_t  i_black_score,
    input  gomoku_pkg::score_t  i_white_score,
    output gomoku_pkg::score_t  o_score,
    output logic                o_finish
);

    import gomoku_pkg::*;

    score_t col_diff;
    score_t run_sum;
    score_t total;
    logic   first_q;

    assign col_diff = i_black_score - i_white_score;
    assign total    = (first_q ? score_t'(0) : run_sum) + col_diff;   // First column restarts.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            first_q  <= 1'b1;
            o_score  <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= i_black_valid && i_black_last;
            if (i_black_valid) begin
                first_q <= i_black_last;
                if (i_black_last) begin
                    o_score <= total;                  // Held until the next board.
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_black_valid) begin
            run_sum <= total;
        end
    end

endmodule

/* hw/gomoku_eval.sv */
`include "gomoku_config.svh"

module gomoku_eval (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  logic [2*`CELL_COUNT-1:0]       i_board,
    output logic signed [`SCORE_WIDTH-1:0] o_score,
    output logic                           o_finish
);

    import gomoku_pkg::*;

    logic    col_valid;
    logic    col_last;
    column_t col_cells;

    // Lane 0 scores black, lane 1 white.
    logic    lane_valid [2];
    logic    lane_last  [2];
    score_t  lane_score [2];

    column_feeder u_column_feeder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_board     (i_board),
        .o_col_valid (col_valid),
        .o_col_last  (col_last),
        .o_col_cells (col_cells)
    );

    for (genvar g = 0; g < 2; g++) begin : g_lane
        line_matcher #(
            .OWN_COLOR (cell_t'(g))
        ) u_line_matcher (
            .i_clk        (i_clk),
            .i_rst_n      (i_rst_n),
            .i_col_valid  (col_valid),
            .i_col_last   (col_last),
            .i_col_cells  (col_cells),
            .o_lane_valid (lane_valid[g]),
            .o_lane_last  (lane_last[g]),
            .o_lane_score (lane_score[g])
        );
    end

    // Lanes run in lockstep, so the black lane paces the sum.
    score_accumulator u_score_accumulator (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_black_valid (lane_valid[0]),
        .i_black_last  (lane_last[0]),
        .i_black_score (lane_score[0]),
        .i_white_score (lane_score[1]),
        .o_score       (o_score),
        .o_finish      (o_finish)
    );

endmodule

/* sim/gomoku_eval_tb.sv */
`include "gomoku_config.svh"

module gomoku_eval_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int FINISH_LATENCY = 17;                     // Start edge to finish edge.
    localparam int B2B_GAP        = 15;                     // Earliest next start.
    localparam int BUSY_PULSE_AT  = 5;                      // Stray start while busy.

    localparam logic [2*`CELL_COUNT-1:0] EMPTY_BOARD = {`CELL_COUNT{2'b10}};
    localparam logic [2*`CELL_COUNT-1:0] DECOY_BOARD = '0;  // All black.

    logic                           i_clk;
    logic                           i_rst_n;
    logic                           i_start;
    logic [2*`CELL_COUNT-1:0]       i_board;
    logic signed [`SCORE_WIDTH-1:0] o_score;
    logic                           o_finish;

    logic [2*`CELL_COUNT-1:0]       boards  [$];
    string                          names   [$];
    int                             modes   [$];
    int                             expects [$];

    // Evaluations started but not yet finished.
    logic signed [`SCORE_WIDTH-1:0] pend_score [$];
    int                             pend_edge  [$];
    string                          pend_name  [$];

    logic signed [`SCORE_WIDTH-1:0] last_score  = '0;
    int                             cycle       = 0;
    int                             cycle_limit = 0;

    gomoku_eval i_gomoku_eval (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_board  (i_board),
        .o_score  (o_score),
        .o_finish (o_finish)
    );

    always #CLK_HALF i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;                                 // Number of the last rising edge.
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run stopped on error.");
    endtask

    task automatic check(input logic signed [63:0] actual, input logic signed [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
            $display("TEST FAIL");
            $fatal(1, "Run stopped on mismatch.");
        end
    endtask

    task automatic load_patterns();
        int                       fd;
        int                       n;
        int                       runs_left;
        int                       mode;
        int                       runs;
        int                       expected;
        int                       row;
        int                       col;
        int                       color;
        int                       len;
        string                    line;
        string                    name;
        logic [2*`CELL_COUNT-1:0] board;
        fd = $fopen("sim/gomoku_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the pattern file sim/gomoku_patterns.txt.");
        end else begin
            runs_left = 0;
            board     = EMPTY_BOARD;
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) == "#") begin
                    continue;
                end
                if (runs_left == 0) begin
                    n = $sscanf(line, "%s %d %d %d", name, mode, runs, expected);
                    if (n == 4) begin
                        board     = EMPTY_BOARD;
                        runs_left = runs;
                        names.push_back(name);
                        modes.push_back(mode);
                        expects.push_back(expected);
                        if (runs == 0) begin
                            boards.push_back(board);
                        end
                    end else if (n > 0) begin
                        abort_run({"The pattern file has a malformed header line: ", line});
                    end
                end else begin
                    n = $sscanf(line, "%d %d %d %d", row, col, color, len);
                    if (n != 4 || row < 0 || len < 1 || row + len > `BOARD_SIZE ||
                        col < 0 || col >= `BOARD_SIZE || color < 0 || color > 1) begin
                        abort_run({"The pattern file has a malformed stone line: ", line});
                    end else begin
                        // A run of stones going down one column.
                        for (int k = 0; k < len; k++) begin
                            board[2*((row + k)*`BOARD_SIZE + col) +: 2] = color[1:0];
                        end
                        runs_left--;
                        if (runs_left == 0) begin
                            boards.push_back(board);
                        end
                    end
                end
            end
            $fclose(fd);
            if (runs_left != 0 || boards.size() == 0) begin
                abort_run("The pattern file is empty or ends inside a record.");
            end
        end
    endtask

    task automatic advance_to_edge(input int edge_num);
        while (cycle < edge_num) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_idle();
        while (pend_score.size() != 0) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic start_eval(input int idx);
        i_board = boards[idx];
        i_start = 1'b1;
        pend_score.push_back(expects[idx]);
        pend_edge.push_back(cycle + 1);                     // Sampled at the next edge.
        pend_name.push_back(names[idx]);
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_start = 1'b0;
        i_board = DECOY_BOARD;                              // Board is latched by now.
    endtask

    // Outputs are sampled mid-cycle.
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_finish) begin
                if (pend_score.size() == 0) begin
                    abort_run("o_finish pulsed while no evaluation was in flight.");
                end else begin
                    check(o_score, pend_score[0], {pend_name[0], " score"});
                    check(cycle, pend_edge[0] + FINISH_LATENCY,
                          {pend_name[0], " finish edge"});
                    last_score = pend_score[0];
                    void'(pend_score.pop_front());
                    void'(pend_edge.pop_front());
                    void'(pend_name.pop_front());
                end
            end else begin
                check(o_score, last_score, "o_score held between evaluations");
            end
        end
    end

    always @(posedge i_clk) begin
        if (cycle >= cycle_limit) begin
            abort_run("Timeout: the evaluations did not finish within the cycle limit.");
        end
    end

    initial begin
        int last_start;
        i_clk      = 1'b0;
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        i_board    = EMPTY_BOARD;
        last_start = 0;
        load_patterns();
        cycle_limit = (boards.size() + 2) * 25;
        repeat (2) @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;
        check(o_finish, 1'b0, "o_finish after reset");
        check(o_score, 0, "o_score after reset");

        // Mode 0 starts when idle, mode 1 right after the last column.
        for (int idx = 0; idx < boards.size(); idx++) begin
            if (modes[idx] == 1) begin
                advance_to_edge(last_start + B2B_GAP - 1);
            end else begin
                wait_idle();
            end
            start_eval(idx);
            last_start = cycle;
            if (modes[idx] == 2) begin
                advance_to_edge(last_start + BUSY_PULSE_AT - 1);
                i_start = 1'b1;                             // Must be ignored.
                i_board = DECOY_BOARD;
                @(posedge i_clk);
                #DRIVE_DELAY;
                i_start = 1'b0;
            end
        end

        wait_idle();
        repeat (4) @(posedge i_clk);                        // Catch stray finish pulses.
        $display("TEST PASS");
        $finish;
    end

endmodule

/* gomoku_eval.f */
+incdir+hw
hw/gomoku_pkg.sv
hw/column_feeder.sv
hw/line_matcher.sv
hw/score_accumulator.sv
hw/gomoku_eval.sv
sim/gomoku_eval_tb.sv

/* sim/gomoku_patterns.txt */
# Header: name mode runs expected_score; mode 0 starts idle, 1 starts 15 edges after the last
# start, 2 starts idle and pulses a start while busy. Run: row col color(0 black, 1 white) length
empty_board 0 0 0
black_five 0 1 1000000
5 3 0 5
black_open_four 0 1 100000
5 3 0 4
black_blocked_four 0 2 10000
4 3 1 1
5 3 0 4
black_open_three 0 1 1000
5 3 0 3
black_blocked_three 0 2 100
4 3 1 1
5 3 0 3
black_open_two 0 1 100
5 3 0 2
white_all_classes 0 8 -1111200
5 0 1 5
5 2 1 4
5 4 1 4
9 4 0 1
5 6 1 3
5 8 1 3
8 8 0 1
5 10 1 2
mixed_board 0 2 99000
3 2 0 4
9 7 1 3
edge_fours 0 2 0
0 5 0 4
11 9 1 4
horizontal_five 0 5 0
7 2 0 1
7 3 0 1
7 4 0 1
7 5 0 1
7 6 0 1
b2b_edge_five 1 1 1000000
0 0 0 5
b2b_open_three 1 1 -1000
6 14 1 3
busy_start_ignored 2 1 -100000
8 12 1 4
b2b_after_ignore 1 2 900
2 1 0 3
10 13 1 2
